//--- hdl/dynode_crossing_timer.sv
`timescale 1ns/100ps

module dynode_crossing_timer #(
	parameter logic [11:0] TIME_ADJ = dynode_pkg::DEF_TIME_ADJ
) (
	input  logic clk,
	input  logic capture_en,  // armed, track sd every cycle
	input  logic latch_time,  // load evntim
	input  dynode_pkg::diff_t sd,
	input  dynode_pkg::diff_t sd_prev,
	input  dynode_pkg::count_t timcnt,
	output logic late,  // adjust carried into the next count
	output dynode_pkg::event_time_t evntim
);
	import dynode_pkg::*;

	diff_t sd_pos;       // last sd before crossing
	diff_t sd_after;     // first negative sd
	count_t cross_cnt;   // count at the crossing
	diff_t sd_delta;     // step across zero
	logic [2:0] norm_sh;
	logic [7:0] delta_norm;  // table index
	logic [8:0] pos_norm;
	recip_t recip;
	logic [24:0] frac;  // only 15:4 make it into the time
	event_time_t adj_time;

	// keeps the final pair once capture_en drops
	always_ff @(posedge clk) begin
		if (capture_en) begin
			sd_pos <= sd_prev;
			sd_after <= sd;
			cross_cnt <= timcnt;
		end
		sd_delta <= sd_pos - sd_after;
	end

	// find the highest set bit in 13..8 of the step
	always_comb begin
		norm_sh = 3'd0;
		for (int i = 8; i <= 13; i++) begin
			if (sd_delta[i])
				norm_sh = 3'(i - 7);  // last hit is the highest
		end
	end

	// same shift on both keeps the ratio
	assign delta_norm = 8'(sd_delta >> norm_sh);
	assign pos_norm = 9'(sd_pos >> norm_sh);
	assign recip = dynode_recip(delta_norm);
	assign frac = pos_norm * recip;  // sd_pos / sd_delta, 16 bit fraction

	always_comb begin
		adj_time.word = {4'h0, cross_cnt, frac[15:4]} + {12'h000, TIME_ADJ};
	end

	// bottom of coarse no longer matches the captured count
	assign late = adj_time.field.coarse[0] != cross_cnt[0];

	always_ff @(posedge clk) begin
		if (latch_time)
			evntim <= adj_time;  // held until the next event
	end

endmodule

//--- hdl/dynode_derivative.sv
`timescale 1ns/100ps

module dynode_derivative #(
	parameter int FD_ON = dynode_pkg::DEF_FD_ON,  // fd level for arming
	parameter int SD_ON = dynode_pkg::DEF_SD_ON   // sd level for arming
) (
	input  logic clk,
	input  dynode_pkg::smooth_t smoothed,
	output dynode_pkg::diff_t sd,       // second difference
	output dynode_pkg::diff_t sd_prev,  // sd one cycle back
	output logic fd_over,
	output logic sd_over,
	output logic sd_neg
);
	import dynode_pkg::*;

	smooth_t smoothed_d;
	diff_t fd;       // first difference
	diff_t fd_prev;

	always_ff @(posedge clk) begin
		smoothed_d <= smoothed;
		fd <= diff_t'({1'b0, smoothed}) - diff_t'({1'b0, smoothed_d});
		fd_prev <= fd;
		sd <= fd - fd_prev;
		sd_prev <= sd;  // last sample before a crossing
	end

	// level flags count only on a rising slope
	assign fd_over = !fd[DIFF_W-1] && (fd > diff_t'(FD_ON));
	assign sd_over = !sd[DIFF_W-1] && (sd > diff_t'(SD_ON));
	assign sd_neg = sd[DIFF_W-1];  // sd crossed zero

endmodule

//--- hdl/dynode_event_ctrl.sv
`timescale 1ns/100ps

module dynode_event_ctrl #(
	parameter int PU_WINDOW = dynode_pkg::PILEUP_WINDOW  // max wait for sd crossing
) (
	input  logic clk,
	input  logic reset,
	input  logic indet,
	input  logic fd_over,
	input  logic sd_over,
	input  logic sd_neg,
	input  logic late,
	output logic capture_en,
	output logic latch_time,
	output logic evnt,     // event strobe
	output logic pileup,
	output logic pudump    // armed event dropped
);
	localparam int CNT_W = $clog2(PU_WINDOW + 1);

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_WAIT = 3'd1;       // armed, wait for sd < 0
	localparam logic [2:0] ST_COMPUTE = 3'd2;    // step across zero
	localparam logic [2:0] ST_LATCH = 3'd3;      // load event time
	localparam logic [2:0] ST_EMIT = 3'd4;
	localparam logic [2:0] ST_EMIT_LATE = 3'd5;  // strobe one cycle later

	logic [2:0] state;
	logic fd_seen;  // sticky fd level
	logic sd_seen;  // sticky sd level
	logic arm;
	logic [CNT_W-1:0] pu_cnt;

	assign arm = (state == ST_IDLE) && indet && (fd_seen || fd_over) && (sd_seen || sd_over);

	// levels may arrive in different cycles within one indet
	always_ff @(posedge clk) begin
		if (reset || !indet || arm || state != ST_IDLE) begin
			fd_seen <= 1'b0;
			sd_seen <= 1'b0;
		end else begin
			fd_seen <= fd_seen | fd_over;
			sd_seen <= sd_seen | sd_over;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			pu_cnt <= '0;
			pudump <= 1'b0;
		end else begin
			pudump <= 1'b0;
			case (state)
				ST_IDLE: begin
					pu_cnt <= '0;
					if (arm)
						state <= ST_WAIT;
				end
				ST_WAIT: begin
					pu_cnt <= pu_cnt + 1'b1;
					if (pu_cnt == CNT_W'(PU_WINDOW)) begin
						state <= ST_IDLE;  // crossing too slow
						pudump <= 1'b1;
					end else if (sd_neg) begin
						state <= ST_COMPUTE;
					end
				end
				ST_COMPUTE: state <= ST_LATCH;
				ST_LATCH:   state <= ST_EMIT;
				ST_EMIT:    state <= late ? ST_EMIT_LATE : ST_IDLE;
				default:    state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			pileup <= 1'b0;
		else
			pileup <= indet && fd_over;
	end

	assign capture_en = (state == ST_WAIT);
	assign latch_time = (state == ST_LATCH);
	assign evnt = (state == ST_EMIT && !late) || (state == ST_EMIT_LATE);

endmodule

//--- hdl/dynode_eventdet.sv
`timescale 1ns/100ps

module dynode_eventdet #(
	parameter int INDET_ON = dynode_pkg::DEF_INDET_ON,
	parameter int INDET_OFF = dynode_pkg::DEF_INDET_OFF,
	parameter int FD_ON = dynode_pkg::DEF_FD_ON,
	parameter int SD_ON = dynode_pkg::DEF_SD_ON,
	parameter logic [11:0] TIME_ADJ = dynode_pkg::DEF_TIME_ADJ,
	parameter int PU_WINDOW = dynode_pkg::PILEUP_WINDOW
) (
	input  logic clk,
	input  logic reset,
	input  dynode_pkg::sample_t sample,  // one adc sample per clock
	input  dynode_pkg::count_t timcnt,   // coarse time counter
	input  dynode_pkg::smooth_mode_t smooth_mode,
	output logic indet,   // event may be present
	output logic evnt,    // event time ready
	output logic pileup,
	output logic pudump,
	output dynode_pkg::event_time_t evntim
);
	import dynode_pkg::*;

	smooth_t smoothed;
	diff_t sd;
	diff_t sd_prev;
	logic fd_over;
	logic sd_over;
	logic sd_neg;
	logic capture_en;
	logic latch_time;
	logic late;

	dynode_smoother #(
		.INDET_ON(INDET_ON),
		.INDET_OFF(INDET_OFF)
	) smoother_i (
		.clk(clk), .reset(reset), .sample(sample), .smooth_mode(smooth_mode),
		.smoothed(smoothed), .indet(indet)
	);

	dynode_derivative #(.FD_ON(FD_ON), .SD_ON(SD_ON)) derivative_i (
		.clk(clk), .smoothed(smoothed), .sd(sd), .sd_prev(sd_prev),
		.fd_over(fd_over), .sd_over(sd_over), .sd_neg(sd_neg)
	);

	dynode_event_ctrl #(.PU_WINDOW(PU_WINDOW)) event_ctrl_i (
		.clk(clk), .reset(reset), .indet(indet), .fd_over(fd_over),
		.sd_over(sd_over), .sd_neg(sd_neg), .late(late),
		.capture_en(capture_en), .latch_time(latch_time),
		.evnt(evnt), .pileup(pileup), .pudump(pudump)
	);

	// interpolated time of the sd zero crossing
	dynode_crossing_timer #(.TIME_ADJ(TIME_ADJ)) crossing_timer_i (
		.clk(clk), .capture_en(capture_en), .latch_time(latch_time),
		.sd(sd), .sd_prev(sd_prev), .timcnt(timcnt),
		.late(late), .evntim(evntim)
	);

endmodule

//--- hdl/dynode_pkg.sv
package dynode_pkg;

	localparam int SAMPLE_W = 12;  // adc bits
	localparam int SMOOTH_W = 14;  // room for four samples
	localparam int DIFF_W = 15;    // one more for the sign
	localparam int COUNT_W = 8;
	localparam int RECIP_W = 16;

	typedef logic [SAMPLE_W-1:0] sample_t;  // baseline corrected
	typedef logic [SMOOTH_W-1:0] smooth_t;
	typedef logic signed [DIFF_W-1:0] diff_t;  // msb is the sign
	typedef logic [COUNT_W-1:0] count_t;  // coarse time
	typedef logic [RECIP_W-1:0] recip_t;

	// any code not listed gives one point times four
	typedef enum logic [3:0] {
		SMOOTH_TWO      = 4'd2,  // two points doubled
		SMOOTH_THREE    = 4'd3,
		SMOOTH_FOUR     = 4'd4,
		SMOOTH_WEIGHTED = 4'd5   // middle point counted twice
	} smooth_mode_t;

	typedef union packed {
		logic [23:0] word;  // flat view for the adjust add
		struct packed {
			logic [11:0] coarse;  // count at the bottom, carries above
			logic [11:0] fine;    // fraction of a clock
		} field;
	} event_time_t;

	localparam int PILEUP_WINDOW = 4;  // cycles allowed waiting for sd crossing
	localparam int DEF_INDET_ON = 256;
	localparam int DEF_INDET_OFF = 128;
	localparam int DEF_FD_ON = 512;  // fd minimum
	localparam int DEF_SD_ON = 384;  // sd minimum
	localparam logic [11:0] DEF_TIME_ADJ = 12'hA00;  // sd time offset

	function automatic recip_t dynode_recip(input logic [7:0] value);
		`include "dynode_recip_table.svh"
		return RECIP_TABLE[value];
	endfunction

endpackage

//--- hdl/dynode_smoother.sv
`timescale 1ns/100ps

module dynode_smoother #(
	parameter int INDET_ON = dynode_pkg::DEF_INDET_ON,   // turn on level
	parameter int INDET_OFF = dynode_pkg::DEF_INDET_OFF  // turn off level
) (
	input  logic clk,
	input  logic reset,
	input  dynode_pkg::sample_t sample,  // baseline corrected adc
	input  dynode_pkg::smooth_mode_t smooth_mode,
	output dynode_pkg::smooth_t smoothed,
	output logic indet  // event may be present
);
	import dynode_pkg::*;

	sample_t sample_d [0:2];  // last three samples
	smooth_t s0;
	smooth_t s1;
	smooth_t s2;
	smooth_t s3;

	// zero extend so the sums do not wrap
	assign s0 = smooth_t'(sample);
	assign s1 = smooth_t'(sample_d[0]);
	assign s2 = smooth_t'(sample_d[1]);
	assign s3 = smooth_t'(sample_d[2]);

	always_ff @(posedge clk) begin
		sample_d[0] <= sample;
		sample_d[1] <= sample_d[0];
		sample_d[2] <= sample_d[1];
	end

	// all patterns scale to four times a sample except three point
	always_ff @(posedge clk) begin
		case (smooth_mode)
			SMOOTH_TWO:      smoothed <= (s0 + s1) << 1;
			SMOOTH_THREE:    smoothed <= s0 + s1 + s2;
			SMOOTH_FOUR:     smoothed <= s0 + s1 + s2 + s3;
			SMOOTH_WEIGHTED: smoothed <= s0 + (s1 << 1) + s2;  // center twice
			default:         smoothed <= s0 << 2;  // single point
		endcase
	end

	// hysteresis on the smoothed level
	always_ff @(posedge clk) begin
		if (reset) begin
			indet <= 1'b0;
		end else if (!indet) begin
			indet <= (smoothed > INDET_ON);
		end else begin
			indet <= (smoothed >= INDET_OFF);  // hold until below the off level
		end
	end

endmodule

//--- include/dynode_recip_table.svh
`ifndef DYNODE_RECIP_TABLE_SVH
`define DYNODE_RECIP_TABLE_SVH
// 65536 / n, floored; 0 and 1 saturate
localparam recip_t RECIP_TABLE [0:255] = '{
	16'hFFFF, 16'hFFFF, 16'h8000, 16'h5555,  // 0
	16'h4000, 16'h3333, 16'h2AAA, 16'h2492,
	16'h2000, 16'h1C71, 16'h1999, 16'h1745,
	16'h1555, 16'h13B1, 16'h1249, 16'h1111,
	16'h1000, 16'h0F0F, 16'h0E38, 16'h0D79,  // 16
	16'h0CCC, 16'h0C30, 16'h0BA2, 16'h0B21,
	16'h0AAA, 16'h0A3D, 16'h09D8, 16'h097B,
	16'h0924, 16'h08D3, 16'h0888, 16'h0842,
	16'h0800, 16'h07C1, 16'h0787, 16'h0750,  // 32
	16'h071C, 16'h06EB, 16'h06BC, 16'h0690,
	16'h0666, 16'h063E, 16'h0618, 16'h05F4,
	16'h05D1, 16'h05B0, 16'h0590, 16'h0572,
	16'h0555, 16'h0539, 16'h051E, 16'h0505,  // 48
	16'h04EC, 16'h04D4, 16'h04BD, 16'h04A7,
	16'h0492, 16'h047D, 16'h0469, 16'h0456,
	16'h0444, 16'h0432, 16'h0421, 16'h0410,
	16'h0400, 16'h03F0, 16'h03E0, 16'h03D2,  // 64
	16'h03C3, 16'h03B5, 16'h03A8, 16'h039B,
	16'h038E, 16'h0381, 16'h0375, 16'h0369,
	16'h035E, 16'h0353, 16'h0348, 16'h033D,
	16'h0333, 16'h0329, 16'h031F, 16'h0315,  // 80
	16'h030C, 16'h0303, 16'h02FA, 16'h02F1,
	16'h02E8, 16'h02E0, 16'h02D8, 16'h02D0,
	16'h02C8, 16'h02C0, 16'h02B9, 16'h02B1,
	16'h02AA, 16'h02A3, 16'h029C, 16'h0295,  // 96
	16'h028F, 16'h0288, 16'h0282, 16'h027C,
	16'h0276, 16'h0270, 16'h026A, 16'h0264,
	16'h025E, 16'h0259, 16'h0253, 16'h024E,
	16'h0249, 16'h0243, 16'h023E, 16'h0239,  // 112
	16'h0234, 16'h0230, 16'h022B, 16'h0226,
	16'h0222, 16'h021D, 16'h0219, 16'h0214,
	16'h0210, 16'h020C, 16'h0208, 16'h0204,
	16'h0200, 16'h01FC, 16'h01F8, 16'h01F4,  // 128
	16'h01F0, 16'h01EC, 16'h01E9, 16'h01E5,
	16'h01E1, 16'h01DE, 16'h01DA, 16'h01D7,
	16'h01D4, 16'h01D0, 16'h01CD, 16'h01CA,
	16'h01C7, 16'h01C3, 16'h01C0, 16'h01BD,  // 144
	16'h01BA, 16'h01B7, 16'h01B4, 16'h01B2,
	16'h01AF, 16'h01AC, 16'h01A9, 16'h01A6,
	16'h01A4, 16'h01A1, 16'h019E, 16'h019C,
	16'h0199, 16'h0197, 16'h0194, 16'h0192,  // 160
	16'h018F, 16'h018D, 16'h018A, 16'h0188,
	16'h0186, 16'h0183, 16'h0181, 16'h017F,
	16'h017D, 16'h017A, 16'h0178, 16'h0176,
	16'h0174, 16'h0172, 16'h0170, 16'h016E,  // 176
	16'h016C, 16'h016A, 16'h0168, 16'h0166,
	16'h0164, 16'h0162, 16'h0160, 16'h015E,
	16'h015C, 16'h015A, 16'h0158, 16'h0157,
	16'h0155, 16'h0153, 16'h0151, 16'h0150,  // 192
	16'h014E, 16'h014C, 16'h014A, 16'h0149,
	16'h0147, 16'h0146, 16'h0144, 16'h0142,
	16'h0141, 16'h013F, 16'h013E, 16'h013C,
	16'h013B, 16'h0139, 16'h0138, 16'h0136,  // 208
	16'h0135, 16'h0133, 16'h0132, 16'h0130,
	16'h012F, 16'h012E, 16'h012C, 16'h012B,
	16'h0129, 16'h0128, 16'h0127, 16'h0125,
	16'h0124, 16'h0123, 16'h0121, 16'h0120,  // 224
	16'h011F, 16'h011E, 16'h011C, 16'h011B,
	16'h011A, 16'h0119, 16'h0118, 16'h0116,
	16'h0115, 16'h0114, 16'h0113, 16'h0112,
	16'h0111, 16'h010F, 16'h010E, 16'h010D,  // 240
	16'h010C, 16'h010B, 16'h010A, 16'h0109,
	16'h0108, 16'h0107, 16'h0106, 16'h0105,
	16'h0104, 16'h0103, 16'h0102, 16'h0101
};
`endif

//--- project.f
+incdir+include
hdl/dynode_pkg.sv
hdl/dynode_smoother.sv
hdl/dynode_derivative.sv
hdl/dynode_crossing_timer.sv
hdl/dynode_event_ctrl.sv
hdl/dynode_eventdet.sv
test/dynode_ref_model.sv
test/dynode_eventdet_tb.sv

//--- test/dynode_eventdet_tb.sv
`timescale 1ns/100ps

module dynode_eventdet_tb;
	import dynode_pkg::*;
	import dynode_ref_model::*;

	localparam int RESET_CYCLES = 10;
	localparam int NUM_SAMPLES = 3000;
	localparam int TAIL_CYCLES = 20;  // let the last event drain
	localparam int CYCLE_LIMIT = NUM_SAMPLES + 200;

	logic clk = 1'b0;
	logic reset;
	sample_t sample;
	count_t timcnt;
	smooth_mode_t smooth_mode;
	logic indet;
	logic evnt;
	logic pileup;
	logic pudump;
	event_time_t evntim;

	int samples [$];  // stimulus, one entry per clock
	int modes [$];
	int errors = 0;
	int other_errors = 0;
	int events_seen = 0;
	int dumps_seen = 0;
	int cycle_cnt = 0;

	dynode_eventdet dynode_eventdet_i (
		.clk(clk), .reset(reset), .sample(sample), .timcnt(timcnt),
		.smooth_mode(smooth_mode), .indet(indet), .evnt(evnt),
		.pileup(pileup), .pudump(pudump), .evntim(evntim)
	);

	always #4 clk = ~clk;  // 8 ns period

	// hard stop in case the main loop never ends
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("timeout: run went past %0d cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic check_bit(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			errors++;
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, expected);
		end
	endtask

	task automatic check_time(input string name, input event_time_t got,
			input event_time_t expected);
		if (got !== expected) begin
			errors++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name,
				got.word, expected.word);
		end
	endtask

	// small positive noise on top of the shape
	task automatic add_sample(input int value, input int mode_code);
		int v;
		v = value + int'($urandom % 8);
		if (v > 4095)
			v = 4095;
		samples.push_back(v);
		modes.push_back(mode_code);
	endtask

	task automatic add_rise(inout int level, input int peak, input int steps,
			input int mode_code);
		int base;
		base = level;
		for (int t = 1; t <= steps; t++) begin
			level = base + (peak - base) * t / steps;  // straight ramp
			add_sample(level, mode_code);
		end
	endtask

	task automatic add_decay(inout int level, input int steps, input int mode_code);
		for (int t = 0; t < steps && level > 8; t++) begin
			level = level * 7 / 8;  // dynode tail
			add_sample(level, mode_code);
		end
	endtask

	// cubic start so sd keeps growing past the wait window
	task automatic add_slow_rise(inout int level, input int mode_code);
		for (int t = 1; t <= 11; t++) begin
			level = 3 * t * t * t;
			add_sample(level, mode_code);
		end
	endtask

	task automatic build_stimulus();
		int kind;
		int mode_code;
		int level;
		int peak;
		mode_code = 0;
		while (samples.size() < NUM_SAMPLES - 150) begin
			kind = $urandom % 4;
			mode_code = $urandom % 16;  // codes outside 2 to 5 are single point
			level = 0;
			repeat (20 + $urandom % 40)
				add_sample(0, mode_code);
			case (kind)
				2: begin
					add_slow_rise(level, mode_code);
					add_decay(level, 60, mode_code);
				end
				3: begin
					peak = 1200 + $urandom % 1200;
					add_rise(level, peak, 1 + $urandom % 3, mode_code);
					add_decay(level, 3 + $urandom % 6, mode_code);
					peak = level + 800 + $urandom % 1200;  // second pulse on the tail
					add_rise(level, peak, 1 + $urandom % 3, mode_code);
					add_decay(level, 60, mode_code);
				end
				default: begin
					peak = 1500 + $urandom % 2400;
					add_rise(level, peak, 1 + $urandom % 3, mode_code);
					add_decay(level, 60, mode_code);
				end
			endcase
		end
		while (samples.size() < NUM_SAMPLES)
			add_sample(0, mode_code);
	endtask

	task automatic compare_outputs();
		bit exp_evnt;
		exp_evnt = evnt_now();
		check_bit("indet", indet, indet_r);
		check_bit("pileup", pileup, pileup_r);
		check_bit("pudump", pudump, pudump_r);
		check_bit("evnt", evnt, exp_evnt);
		if (exp_evnt) begin
			events_seen++;
			check_time("evntim", evntim, evntim_r);  // only valid on the strobe
		end
		if (pudump_r)
			dumps_seen++;
	endtask

	initial begin
		int idx;
		void'($urandom(32'h967b5d04));
		reset = 1'b1;
		sample = '0;
		timcnt = '0;
		smooth_mode = SMOOTH_FOUR;
		build_stimulus();
		step_model(reset, int'(sample), int'(smooth_mode), int'(timcnt));  // first edge
		for (int i = 1; i < RESET_CYCLES + NUM_SAMPLES + TAIL_CYCLES; i++) begin
			@(negedge clk);
			compare_outputs();
			idx = i - RESET_CYCLES;
			reset = (i < RESET_CYCLES);
			timcnt = timcnt + 1'b1;  // free running coarse time
			if (idx >= 0 && idx < NUM_SAMPLES) begin
				sample = sample_t'(samples[idx]);
				smooth_mode = smooth_mode_t'(modes[idx]);
			end else begin
				sample = '0;
			end
			step_model(reset, int'(sample), int'(smooth_mode), int'(timcnt));
		end
		@(negedge clk);
		compare_outputs();
		if (events_seen == 0) begin
			other_errors++;
			$display("no event strobe occurred during the whole run");
		end
		if (dumps_seen == 0) begin
			other_errors++;
			$display("no pileup dump occurred during the whole run");
		end
		$display("mismatches %0d, other errors %0d, events %0d, dumps %0d",
			errors, other_errors, events_seen, dumps_seen);
		if (errors == 0 && other_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- test/dynode_ref_model.sv
package dynode_ref_model;
	import dynode_pkg::*;

	localparam int ST_IDLE = 0;
	localparam int ST_WAIT = 1;
	localparam int ST_COMPUTE = 2;
	localparam int ST_LATCH = 3;
	localparam int ST_EMIT = 4;
	localparam int ST_EMIT_LATE = 5;

	int hist [0:2];  // last three samples with the newest first
	int smoothed_r;
	bit indet_r;
	int smoothed_d_r;
	int fd_r;
	int fd_prev_r;
	int sd_r;
	int sd_prev_r;
	bit fd_seen_r;
	bit sd_seen_r;
	int state_r;
	int wait_cnt_r;  // cycles spent armed
	bit pudump_r;
	bit pileup_r;
	int sd_pos_r;
	int sd_after_r;
	int cross_cnt_r;
	int sd_delta_r;
	event_time_t evntim_r;

	// wrap to the 15 bit signed difference width
	function automatic int to_diff(input int v);
		int m;
		m = v & 32'h7FFF;
		if (m >= 16384)
			m = m - 32768;
		return m;
	endfunction

	// plain division saturated at the bottom
	function automatic int recip_value(input int v);
		if (v < 2)
			return 16'hFFFF;
		return 65536 / v;
	endfunction

	function automatic int smooth_sum(input int mode, input int s0, input int s1,
			input int s2, input int s3);
		case (mode)
			SMOOTH_TWO:      return (s0 + s1) * 2;
			SMOOTH_THREE:    return s0 + s1 + s2;
			SMOOTH_FOUR:     return s0 + s1 + s2 + s3;
			SMOOTH_WEIGHTED: return s0 + 2 * s1 + s2;
			default:         return s0 * 4;
		endcase
	endfunction

	function automatic bit fd_over_now();
		return fd_r > DEF_FD_ON;  // also implies positive
	endfunction

	function automatic bit sd_over_now();
		return sd_r > DEF_SD_ON;
	endfunction

	// interpolated time from the captured pair and count
	function automatic event_time_t crossing_time();
		int delta;
		int pos;
		int sh;
		int frac;
		event_time_t t;
		delta = sd_delta_r & 32'h7FFF;  // raw 15 bit pattern
		pos = sd_pos_r & 32'h7FFF;
		sh = 0;
		for (int b = 13; b >= 8 && sh == 0; b--) begin
			if (delta[b])
				sh = b - 7;  // top bit down to bit 7
		end
		delta = (delta >> sh) & 32'hFF;
		pos = (pos >> sh) & 32'h1FF;
		frac = pos * recip_value(delta);  // 16 bit fraction
		t.word = 24'((cross_cnt_r << 12) + ((frac >> 4) & 32'hFFF) + DEF_TIME_ADJ);
		return t;
	endfunction

	function automatic bit late_now();
		event_time_t t;
		t = crossing_time();
		return t.field.coarse[0] != cross_cnt_r[0];  // adjust moved the count
	endfunction

	function automatic bit evnt_now();
		return (state_r == ST_EMIT && !late_now()) || state_r == ST_EMIT_LATE;
	endfunction

	// one rising clock edge with the given inputs
	function automatic void step_model(input bit rst, input int sample, input int mode,
			input int timcnt);
		bit arm;
		bit capture;
		int n_smoothed;
		bit n_indet;
		int n_fd;
		int n_sd;
		int n_delta;
		int n_state;
		int n_cnt;
		bit n_pudump;
		bit n_pileup;
		event_time_t n_time;
		arm = state_r == ST_IDLE && indet_r && (fd_seen_r || fd_over_now())
			&& (sd_seen_r || sd_over_now());
		capture = state_r == ST_WAIT;
		n_smoothed = smooth_sum(mode, sample, hist[0], hist[1], hist[2]) & 32'h3FFF;
		if (rst)
			n_indet = 1'b0;
		else if (indet_r)
			n_indet = smoothed_r >= DEF_INDET_OFF;  // falls only below the off level
		else
			n_indet = smoothed_r > DEF_INDET_ON;
		n_fd = to_diff(smoothed_r - smoothed_d_r);
		n_sd = to_diff(fd_r - fd_prev_r);
		n_delta = to_diff(sd_pos_r - sd_after_r);
		n_state = state_r;
		n_cnt = wait_cnt_r;
		n_pudump = 1'b0;
		if (rst) begin
			n_state = ST_IDLE;
			n_cnt = 0;
		end else begin
			case (state_r)
				ST_IDLE: begin
					n_cnt = 0;
					if (arm)
						n_state = ST_WAIT;
				end
				ST_WAIT: begin
					n_cnt = wait_cnt_r + 1;
					if (wait_cnt_r == PILEUP_WINDOW) begin
						n_state = ST_IDLE;  // crossing never came
						n_pudump = 1'b1;
					end else if (sd_r < 0) begin
						n_state = ST_COMPUTE;
					end
				end
				ST_COMPUTE: n_state = ST_LATCH;
				ST_LATCH:   n_state = ST_EMIT;
				ST_EMIT:    n_state = late_now() ? ST_EMIT_LATE : ST_IDLE;
				default:    n_state = ST_IDLE;
			endcase
		end
		n_pileup = !rst && indet_r && fd_over_now();
		n_time = (state_r == ST_LATCH) ? crossing_time() : evntim_r;

		// sticky levels only build up while idle and indet holds
		if (rst || !indet_r || arm || state_r != ST_IDLE) begin
			fd_seen_r = 1'b0;
			sd_seen_r = 1'b0;
		end else begin
			fd_seen_r = fd_seen_r | fd_over_now();
			sd_seen_r = sd_seen_r | sd_over_now();
		end
		if (capture) begin
			sd_pos_r = sd_prev_r;
			sd_after_r = sd_r;
			cross_cnt_r = timcnt;
		end
		sd_delta_r = n_delta;
		sd_prev_r = sd_r;
		sd_r = n_sd;
		fd_prev_r = fd_r;
		fd_r = n_fd;
		smoothed_d_r = smoothed_r;
		smoothed_r = n_smoothed;
		indet_r = n_indet;
		hist[2] = hist[1];
		hist[1] = hist[0];
		hist[0] = sample;
		state_r = n_state;
		wait_cnt_r = n_cnt;
		pudump_r = n_pudump;
		pileup_r = n_pileup;
		evntim_r = n_time;
	endfunction

endpackage
